// ==== hw/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// one 32-bit word per line.
`define CACHE_LINE_BYTES 4
`define CACHE_BYTES      1024
`define CACHE_LINES      256
`define CACHE_OFFSET_W   2
`define CACHE_INDEX_W    8
`define CACHE_TAG_W      22

`define MEM_WORDS        4096 // 16 KB, wraps above.
`define MEM_ADDR_W       12
`define MEM_LATENCY      6

`endif

// ==== hw/cache_pkg.sv ====
`include "cache_defs.svh"

package cache_pkg;

  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_OFFSET_W-1:0] offset;
  } cache_addr_fields_t;

  // same address word, raw or split.
  typedef union packed {
    logic [31:0]        raw;
    cache_addr_fields_t fields;
  } cache_addr_u;

  typedef struct packed {
    logic [32-`CACHE_TAG_W-2:0] pad;
    logic                       valid;
    logic [`CACHE_TAG_W-1:0]    tag;
  } tag_entry_t;

  typedef enum logic [1:0] {
    SWEEP,
    IDLE,
    LOOKUP,
    MISS_WAIT
  } ctrl_state_e;

endpackage

// ==== hw/mem_pkg.sv ====
package mem_pkg;

  typedef logic [31:0] mem_word_t;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_READ  = 2'd1,
    MEM_WRITE = 2'd2
  } mem_cmd_e;

endpackage

// ==== hw/bram.sv ====
`timescale 1ns/1ps

module bram #(
  parameter int DATA_WIDTH = 32,
  parameter int DEPTH      = 256
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic                     wen,
  input  logic [DATA_WIDTH-1:0]    din,
  output logic [DATA_WIDTH-1:0]    dout
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[addr] <= din;
    end
    dout <= mem[addr]; // read-before-write.
  end

endmodule

// ==== hw/direct_map.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module direct_map (
  input  logic                   clk,
  input  cache_pkg::cache_addr_u lookup_addr,
  output logic                   hit,
  output mem_pkg::mem_word_t     data,
  input  logic                   wr_en,
  input  cache_pkg::cache_addr_u wr_addr,
  input  mem_pkg::mem_word_t     wr_data,
  input  logic                   wr_line_valid
);

  logic [`CACHE_INDEX_W-1:0] ram_index;
  logic [`CACHE_TAG_W-1:0]   tag_q;
  cache_pkg::tag_entry_t     entry_in;
  cache_pkg::tag_entry_t     entry_out;

  // a write takes the port for its cycle.
  assign ram_index = wr_en ? wr_addr.fields.index : lookup_addr.fields.index;

  always_comb begin
    entry_in       = '0;
    entry_in.valid = wr_line_valid;
    entry_in.tag   = wr_addr.fields.tag;
  end

  always_ff @(posedge clk) begin
    tag_q <= lookup_addr.fields.tag;
  end

  bram #(
    .DATA_WIDTH ($bits(mem_pkg::mem_word_t)),
    .DEPTH      (`CACHE_LINES)
  ) data_ram (
    .clk  (clk),
    .addr (ram_index),
    .wen  (wr_en),
    .din  (wr_data),
    .dout (data)
  );

  bram #(
    .DATA_WIDTH ($bits(cache_pkg::tag_entry_t)),
    .DEPTH      (`CACHE_LINES)
  ) tag_ram (
    .clk  (clk),
    .addr (ram_index),
    .wen  (wr_en),
    .din  (entry_in),
    .dout (entry_out)
  );

  assign hit = entry_out.valid && (entry_out.tag == tag_q);

endmodule

// ==== hw/refill_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module refill_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  logic                   req_write,
  input  logic [31:0]            req_addr,
  input  logic [31:0]            req_wdata,
  output logic                   resp_valid,
  output logic                   resp_hit,
  output mem_pkg::mem_word_t     resp_data,
  output logic                   busy,
  output cache_pkg::cache_addr_u lookup_addr,
  input  logic                   hit,
  input  mem_pkg::mem_word_t     data,
  output logic                   wr_en,
  output logic                   wr_line_valid,
  output cache_pkg::cache_addr_u wr_addr,
  output mem_pkg::mem_word_t     wr_data,
  output mem_pkg::mem_cmd_e      mem_cmd,
  output logic [`MEM_ADDR_W-1:0] mem_addr,
  output mem_pkg::mem_word_t     mem_wdata,
  input  logic                   mem_rsp_valid,
  input  mem_pkg::mem_word_t     mem_rdata,
  output logic [15:0]            hit_count,
  output logic [15:0]            miss_count
);

  cache_pkg::ctrl_state_e    state;
  cache_pkg::ctrl_state_e    state_nxt;
  logic [`CACHE_INDEX_W-1:0] sweep_idx;
  cache_pkg::cache_addr_u    addr_q;
  logic                      idle_req;
  logic                      load_go;

  assign idle_req    = req_valid && !busy;
  assign load_go     = idle_req && !req_write;
  assign busy        = !rst_n || (state != cache_pkg::IDLE); // held high through reset.
  assign lookup_addr = req_addr;

  always_comb begin
    state_nxt     = state;
    resp_valid    = 1'b0;
    resp_hit      = 1'b0;
    resp_data     = data;
    wr_en         = 1'b0;
    wr_line_valid = 1'b0;
    wr_addr       = req_addr;
    wr_data       = req_wdata;
    mem_cmd       = mem_pkg::MEM_NONE;
    mem_addr      = req_addr[`MEM_ADDR_W+`CACHE_OFFSET_W-1:`CACHE_OFFSET_W];
    mem_wdata     = req_wdata;
    case (state)
      cache_pkg::SWEEP: begin
        wr_en                = rst_n; // no sweep writes while held in reset.
        wr_addr              = '0;
        wr_addr.fields.index = sweep_idx;
        wr_data              = '0;
        if (sweep_idx == `CACHE_INDEX_W'(`CACHE_LINES - 1)) begin
          state_nxt = cache_pkg::IDLE;
        end
      end
      cache_pkg::IDLE: begin
        if (idle_req && req_write) begin // write-through, allocate.
          wr_en         = 1'b1;
          wr_line_valid = 1'b1;
          mem_cmd       = mem_pkg::MEM_WRITE;
        end else if (load_go) begin
          state_nxt = cache_pkg::LOOKUP;
        end
      end
      cache_pkg::LOOKUP: begin
        mem_addr = addr_q.raw[`MEM_ADDR_W+`CACHE_OFFSET_W-1:`CACHE_OFFSET_W];
        if (hit) begin
          resp_valid = 1'b1;
          resp_hit   = 1'b1;
          state_nxt  = cache_pkg::IDLE;
        end else begin
          mem_cmd   = mem_pkg::MEM_READ;
          state_nxt = cache_pkg::MISS_WAIT;
        end
      end
      cache_pkg::MISS_WAIT: begin
        // fill and answer on the same edge.
        resp_data     = mem_rdata;
        wr_addr       = addr_q;
        wr_data       = mem_rdata;
        wr_line_valid = 1'b1;
        if (mem_rsp_valid) begin
          resp_valid = 1'b1;
          wr_en      = 1'b1;
          state_nxt  = cache_pkg::IDLE;
        end
      end
      default: state_nxt = cache_pkg::SWEEP;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= cache_pkg::SWEEP;
      sweep_idx  <= '0;
      hit_count  <= '0;
      miss_count <= '0;
    end else begin
      state <= state_nxt;
      if (state == cache_pkg::SWEEP) begin
        sweep_idx <= sweep_idx + 1'b1;
      end
      if (state == cache_pkg::LOOKUP) begin
        // counters saturate.
        if (hit && !(&hit_count)) begin
          hit_count <= hit_count + 16'd1;
        end
        if (!hit && !(&miss_count)) begin
          miss_count <= miss_count + 16'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_go) begin
      addr_q <= req_addr;
    end
  end

endmodule

// ==== hw/backing_mem.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module backing_mem (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mem_pkg::mem_cmd_e      mem_cmd,
  input  logic [`MEM_ADDR_W-1:0] mem_addr,
  input  mem_pkg::mem_word_t     mem_wdata,
  output logic                   mem_rsp_valid,
  output mem_pkg::mem_word_t     mem_rdata
);

  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  mem_pkg::mem_word_t mem [`MEM_WORDS];
  logic [CNT_W-1:0]   lat_cnt;
  mem_pkg::mem_word_t rdata_q;

  always_ff @(posedge clk) begin
    if (mem_cmd == mem_pkg::MEM_WRITE) begin
      mem[mem_addr] <= mem_wdata;
    end
    if (mem_cmd == mem_pkg::MEM_READ) begin
      rdata_q <= mem[mem_addr]; // data taken at issue.
    end
  end

  // counts down to the response cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lat_cnt <= '0;
    end else if (mem_cmd == mem_pkg::MEM_READ) begin
      lat_cnt <= CNT_W'(`MEM_LATENCY);
    end else if (lat_cnt != '0) begin
      lat_cnt <= lat_cnt - 1'b1;
    end
  end

  assign mem_rsp_valid = (lat_cnt == CNT_W'(1));
  assign mem_rdata     = rdata_q;

endmodule

// ==== hw/cache_top.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid,
  input  logic               req_write,
  input  logic [31:0]        req_addr,
  input  logic [31:0]        req_wdata,
  output logic               resp_valid,
  output logic               resp_hit,
  output mem_pkg::mem_word_t resp_data,
  output logic               busy,
  output logic [15:0]        hit_count,
  output logic [15:0]        miss_count
);

  cache_pkg::cache_addr_u   lookup_addr;
  cache_pkg::cache_addr_u   wr_addr;
  logic                     hit;
  mem_pkg::mem_word_t       data;
  logic                     wr_en;
  logic                     wr_line_valid;
  mem_pkg::mem_word_t       wr_data;
  mem_pkg::mem_cmd_e        mem_cmd;
  logic [`MEM_ADDR_W-1:0]   mem_addr;
  mem_pkg::mem_word_t       mem_wdata;
  logic                     mem_rsp_valid;
  mem_pkg::mem_word_t       mem_rdata;

  refill_ctrl refill_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .resp_valid    (resp_valid),
    .resp_hit      (resp_hit),
    .resp_data     (resp_data),
    .busy          (busy),
    .lookup_addr   (lookup_addr),
    .hit           (hit),
    .data          (data),
    .wr_en         (wr_en),
    .wr_line_valid (wr_line_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .mem_cmd       (mem_cmd),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rdata     (mem_rdata),
    .hit_count     (hit_count),
    .miss_count    (miss_count)
  );

  direct_map direct_map_inst (
    .clk           (clk),
    .lookup_addr   (lookup_addr),
    .hit           (hit),
    .data          (data),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_line_valid (wr_line_valid)
  );

  backing_mem backing_mem_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_cmd       (mem_cmd),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rdata     (mem_rdata)
  );

endmodule

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tb;

  localparam logic [31:0] SEED = 32'hbc47_dce0;

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  logic               req_write;
  logic [31:0]        req_addr;
  logic [31:0]        req_wdata;
  logic               resp_valid;
  logic               resp_hit;
  mem_pkg::mem_word_t resp_data;
  logic               busy;
  logic [15:0]        hit_count;
  logic [15:0]        miss_count;

  // reference model.
  mem_pkg::mem_word_t      mem_model [int];
  logic                    line_valid [`CACHE_LINES];
  logic [`CACHE_TAG_W-1:0] line_tag [`CACHE_LINES];
  mem_pkg::mem_word_t      line_data [`CACHE_LINES];
  logic [15:0]             exp_hits;
  logic [15:0]             exp_misses;
  logic                    exp_hit;
  mem_pkg::mem_word_t      exp_data;
  logic                    load_pending;
  logic [31:0]             lfsr;
  logic [31:0]             stored_q [$];
  string                   test_name;
  int                      errors;
  int                      loads;
  int                      stores;
  int                      cycles_since_reset;
  logic                    aborted;
  logic [31:0]             addr_a;
  logic [31:0]             addr_b;

  cache_top cache_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_data  (resp_data),
    .busy       (busy),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      cycles_since_reset <= 0;
    end else if (cycles_since_reset < 1000) begin
      cycles_since_reset <= cycles_since_reset + 1;
    end
  end

  // checks run mid-cycle.
  resp_only_for_load: assert property (@(negedge clk) resp_valid |-> load_pending)
    else begin
      errors++;
      $display("resp_valid rose with no load pending in %s", test_name);
    end

  busy_in_sweep: assert property (@(negedge clk)
      (!rst_n || cycles_since_reset < `CACHE_LINES) |-> busy)
    else begin
      errors++;
      $display("busy was low during reset or the sweep in %s", test_name);
    end

  sweep_length: assert property (@(negedge clk)
      (rst_n && cycles_since_reset == `CACHE_LINES) |-> !busy)
    else begin
      errors++;
      $display("busy still high right after the sweep in %s", test_name);
    end

  busy_while_load: assert property (@(negedge clk) disable iff (!rst_n)
      (load_pending && !req_valid) |-> busy)
    else begin
      errors++;
      $display("busy low while a load was pending in %s", test_name);
    end

  response_cycle: assert property (@(negedge clk) disable iff (!rst_n)
      (req_valid && !req_write && !busy) |=> (resp_valid == exp_hit))
    else begin
      errors++;
      $display("Mismatch %s resp_valid after strobe expected %0b actual %0b",
               test_name, exp_hit, resp_valid);
    end

  resp_data_ok: assert property (@(negedge clk) resp_valid |-> (resp_data == exp_data))
    else begin
      errors++;
      $display("Mismatch %s resp_data expected %h actual %h", test_name, exp_data, resp_data);
    end

  resp_hit_ok: assert property (@(negedge clk) resp_valid |-> (resp_hit == exp_hit))
    else begin
      errors++;
      $display("Mismatch %s resp_hit expected %0b actual %0b", test_name, exp_hit, resp_hit);
    end

  counters_ok: assert property (@(negedge clk) disable iff (!rst_n)
      !busy |-> (hit_count == exp_hits && miss_count == exp_misses))
    else begin
      errors++;
      $display("Mismatch %s counters expected %0d/%0d actual %0d/%0d",
               test_name, exp_hits, exp_misses, hit_count, miss_count);
    end

  // fibonacci lfsr, taps 32 22 2 1.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] make_addr(input int tag, input int idx);
    cache_pkg::cache_addr_u a;
    a.raw          = '0;
    a.fields.tag   = `CACHE_TAG_W'(tag);
    a.fields.index = `CACHE_INDEX_W'(idx);
    return a.raw;
  endfunction

  function automatic int word_index(input cache_pkg::cache_addr_u a);
    return int'(a.raw >> `CACHE_OFFSET_W) % `MEM_WORDS; // memory wraps.
  endfunction

  task automatic apply_reset();
    int i;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    load_pending = 1'b0;
    exp_hits     = '0;
    exp_misses   = '0;
    for (i = 0; i < `CACHE_LINES; i++) begin
      line_valid[i] = 1'b0;
    end
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  task automatic wait_not_busy(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (busy !== 1'b0 && n < limit);
    if (busy !== 1'b0) begin
      errors++;
      aborted = 1'b1;
      $display("Timeout: busy stayed high for %0d cycles in %s", limit, test_name);
    end
  endtask

  task automatic wait_response(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (resp_valid !== 1'b1 && n < limit);
    if (resp_valid !== 1'b1) begin
      errors++;
      aborted = 1'b1;
      $display("Timeout: no response within %0d cycles in %s", limit, test_name);
    end
  endtask

  task automatic do_store(input logic [31:0] addr, input mem_pkg::mem_word_t wdata);
    cache_pkg::cache_addr_u a;
    if (aborted) return;
    wait_not_busy(`CACHE_LINES + 20);
    if (aborted) return;
    a.raw = addr;
    @(posedge clk);
    #2;
    req_valid = 1'b1;
    req_write = 1'b1;
    req_addr  = addr;
    req_wdata = wdata;
    mem_model[word_index(a)]   = wdata; // write-through, allocate.
    line_valid[a.fields.index] = 1'b1;
    line_tag[a.fields.index]   = a.fields.tag;
    line_data[a.fields.index]  = wdata;
    stores++;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic do_load(input logic [31:0] addr);
    cache_pkg::cache_addr_u a;
    if (aborted) return;
    wait_not_busy(`CACHE_LINES + 20);
    if (aborted) return;
    a.raw = addr;
    @(posedge clk);
    #2;
    req_valid    = 1'b1;
    req_write    = 1'b0;
    req_addr     = addr;
    exp_hit      = line_valid[a.fields.index] && (line_tag[a.fields.index] == a.fields.tag);
    exp_data     = exp_hit ? line_data[a.fields.index] : mem_model[word_index(a)];
    load_pending = 1'b1;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    wait_response(40);
    if (aborted) return;
    @(posedge clk);
    #2;
    load_pending = 1'b0;
    loads++;
    if (exp_hit) begin
      exp_hits++;
    end else begin
      exp_misses++; // line filled on a miss.
      line_valid[a.fields.index] = 1'b1;
      line_tag[a.fields.index]   = a.fields.tag;
      line_data[a.fields.index]  = exp_data;
    end
  endtask

  // few tags and lines, so aliasing is common.
  task automatic run_random(input int count);
    logic [31:0] addr;
    int          pick;
    int          i;
    for (i = 0; i < count; i++) begin
      if (stored_q.size() == 0 || take_bits(1) == 32'd1) begin
        addr = make_addr(int'(take_bits(2)), int'(take_bits(4)));
        do_store(addr, take_bits(32));
        stored_q.push_back(addr);
      end else begin
        pick = int'(take_bits(16)) % stored_q.size();
        do_load(stored_q[pick]);
      end
    end
  endtask

  initial begin
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    exp_hit   = 1'b0;
    exp_data  = '0;
    errors    = 0;
    loads     = 0;
    stores    = 0;
    aborted   = 1'b0;
    lfsr      = SEED;
    test_name = "reset";
    apply_reset();
    wait_not_busy(`CACHE_LINES + 20);

    addr_a    = make_addr(1, 5);
    addr_b    = make_addr(2, 5); // same index as addr_a.
    test_name = "store_load_hit";
    do_store(addr_a, 32'h1234_5678);
    do_load(addr_a);

    test_name = "alias_miss";
    do_store(addr_a, 32'hcafe_0001);
    do_store(addr_b, 32'hbeef_0002);
    do_load(addr_a);
    test_name = "refill_hit";
    do_load(addr_a);

    test_name = "random";
    run_random(300);

    test_name = "second_reset";
    if (!aborted) begin
      @(posedge clk);
      #2;
      apply_reset();
      wait_not_busy(`CACHE_LINES + 20);
    end
    do_load(addr_a);

    $display("Summary: %0d loads, %0d stores, %0d errors", loads, stores, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== cache_top.f ====
+incdir+hw
hw/cache_pkg.sv
hw/mem_pkg.sv
hw/bram.sv
hw/direct_map.sv
hw/refill_ctrl.sv
hw/backing_mem.sv
hw/cache_top.sv
sim/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# verilator build and run of the cache testbench.

cd "$(dirname "$0")" || exit 1

log=sim.log
: > "$log"

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
  -f cache_top.f --Mdir obj_dir -o cache_sim >> "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

build_lines=$(wc -l < "$log")
./obj_dir/cache_sim >> "$log" 2>&1
status=$?
tail -n +"$((build_lines + 1))" "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$log"; then
  echo "simulation reported errors, see $log"
  exit 1
fi
exit 0
